// File: sim.f
lsu_pkg.sv
lsu_addr_gen.sv
lsu_txn_ctrl.sv
lsu_rdata_align.sv
lsu_top.sv
lsu_assertions.sv
lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - lsu_addr_gen.sv
  - lsu_txn_ctrl.sv
  - lsu_rdata_align.sv
  - lsu_top.sv
  - target: simulation
    files:
      - lsu_assertions.sv
      - lsu_tb.sv

// File: lsu_tb.sv
// Simulation top for the load/store unit with a random-grant memory model and a reference memory
`default_nettype none

module lsu_tb;

  import lsu_pkg::*;

  localparam int MAX_OUTSTANDING = 2;
  localparam int NUM_DIRECTED    = 24;                     // Store and load per size and offset
  localparam int NUM_OPS         = 200;
  localparam int CYCLE_LIMIT     = NUM_OPS * 15 + 1000;    // Worst op length plus margin

  // Expected result of one instruction
  typedef struct packed {
    logic  load;      // Data checked only for loads
    word_t data;
  } exp_t;

  // Granted transfer waiting for its response
  typedef struct packed {
    word_t       rdata;
    logic [31:0] due;   // Cycle of the response
  } pend_t;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  lsu_req_t req;
  logic     req_ready;
  logic     res_valid;
  word_t    res_rdata;
  logic     busy;
  logic     bus_req;
  bus_req_t bus;
  logic     bus_gnt;
  logic     bus_rvalid;
  word_t    bus_rdata;

  word_t       mem [64];        // Bus-side memory of 256 bytes
  logic [7:0]  ref_mem [256];   // Byte image of what memory should hold
  exp_t        exp_q [$];       // One entry per instruction in issue order
  exp_t        res_exp;
  pend_t       pend_q [$];
  pend_t       pend;
  logic [31:0] stim_state;
  logic [31:0] mem_state;
  int unsigned cycle = 0;

  lsu_top #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_lsu_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .res_valid_o  (res_valid),
    .res_rdata_o  (res_rdata),
    .busy_o       (busy),
    .bus_req_o    (bus_req),
    .bus_o        (bus),
    .bus_gnt_i    (bus_gnt),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata)
  );

  bind lsu_top lsu_assertions #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_lsu_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_req_o    (bus_req_o),
    .bus_o        (bus_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .busy_o       (busy_o)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic word_t stim_rand();
    stim_state = lcg(stim_state);
    return stim_state;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped at first error");
  endtask

  // Load value from the byte image extended by size and sign
  function automatic word_t load_value(input addr_t a, input lsu_size_e size, input logic sext);
    word_t v;
    int    n;
    n = 1 << size;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = ref_mem[8'(a + 32'(i))];
    end
    if (sext && n < 4 && v[8*n-1]) begin
      for (int i = n; i < 4; i++) begin
        v[8*i +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  // Address, enables and lanes of one granted part
  task automatic check_transfer(input lsu_req_t op, input addr_t a, input int part);
    addr_t exp_addr;
    be_t   exp_be;
    int    pos;
    exp_addr = (part == 0) ? a : a + 32'(4 - int'(a[1:0]));   // Next word boundary
    exp_be   = '0;
    for (int i = 0; i < (1 << op.size); i++) begin
      pos = int'(a[1:0]) + i;                  // Byte position from the first word
      if (pos / 4 == part) begin
        exp_be[pos % 4] = 1'b1;
        if (op.we) begin
          assert (bus.wdata[8*(pos%4) +: 8] == op.wdata[8*i +: 8])
            else abort_run($sformatf("mismatch bus_o.wdata: got %h expected byte %h in lane %0d",
                                     bus.wdata, op.wdata[8*i +: 8], pos % 4));
        end
      end
    end
    assert (bus.addr == exp_addr)
      else abort_run($sformatf("mismatch bus_o.addr: got %h expected %h", bus.addr, exp_addr));
    assert (bus.be == exp_be)
      else abort_run($sformatf("mismatch bus_o.be: got %h expected %h", bus.be, exp_be));
    assert (bus.we == op.we)
      else abort_run($sformatf("mismatch bus_o.we: got %h expected %h", bus.we, op.we));
  endtask

  // Present one instruction and hold it until accepted
  task automatic issue_op(input word_t op_a, input word_t op_b, input lsu_size_e size,
                          input logic we, input logic sext, input word_t wdata);
    lsu_req_t op;
    addr_t    a;
    int       parts;
    int       grants;
    exp_t     e;
    op.op_a  = op_a;
    op.op_b  = op_b;
    op.wdata = wdata;
    op.we    = we;
    op.size  = size;
    op.sext  = sext;
    a        = op_a + op_b;
    parts    = (int'(a[1:0]) + (1 << size) > 4) ? 2 : 1;    // Crosses a word boundary
    e.load   = !we;
    e.data   = load_value(a, size, sext);
    exp_q.push_back(e);
    if (we) begin
      for (int i = 0; i < (1 << size); i++) begin
        ref_mem[8'(a + 32'(i))] = wdata[8*i +: 8];
      end
    end
    req       <= op;
    req_valid <= 1'b1;
    grants    = 0;
    do begin
      @(posedge clk);
      if (bus_req && bus_gnt) begin
        check_transfer(op, a, grants);
        grants++;
      end
    end while (!req_ready);
    assert (grants == parts)
      else abort_run($sformatf("instruction took %0d bus transfers instead of %0d", grants, parts));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      bus_gnt    <= 1'b0;
      bus_rvalid <= 1'b0;
      pend_q.delete();
    end else begin
      mem_state = lcg(mem_state);
      bus_gnt <= (mem_state[25:24] != 2'b00);         // Grant about three cycles in four
      if (bus_req && bus_gnt) begin
        for (int l = 0; l < 4; l++) begin
          if (bus.we && bus.be[l]) begin
            mem[bus.addr[7:2]][8*l +: 8] = bus.wdata[8*l +: 8];
          end
        end
        pend.rdata = mem[bus.addr[7:2]];
        pend.due   = cycle + (mem_state[29:28] % 2'd3);  // 1 to 3 cycles after grant
        pend_q.push_back(pend);
      end
      bus_rvalid <= 1'b0;
      if (pend_q.size() != 0 && pend_q[0].due <= cycle) begin
        bus_rvalid <= 1'b1;
        bus_rdata  <= pend_q[0].rdata;
        void'(pend_q.pop_front());
      end
    end
  end

  // Results arrive in issue order
  always @(posedge clk) begin
    if (rst_n && res_valid) begin
      assert (exp_q.size() != 0) else abort_run("result valid with no instruction outstanding");
      res_exp = exp_q.pop_front();
      if (res_exp.load) begin
        assert (res_rdata == res_exp.data)
          else abort_run($sformatf("mismatch res_rdata_o: got %h expected %h",
                                   res_rdata, res_exp.data));
      end
    end
  end

  // Cycle limit and bound assertions
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      abort_run("timeout, instructions did not complete within the cycle limit");
    end
    if (u_lsu_top.u_lsu_assertions.fail_cnt != 0) begin
      abort_run("a bus protocol or outstanding count assertion failed");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    word_t r;
    clk        = 1'b0;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    bus_gnt    = 1'b0;
    bus_rvalid = 1'b0;
    bus_rdata  = '0;
    stim_state = 32'd44;
    mem_state  = lcg(32'd44);              // Separate stream for the memory
    for (int a = 0; a < 256; a++) begin
      ref_mem[a] = 8'(a * 29) ^ 8'hc3;      // Distinct value per byte address
    end
    for (int w = 0; w < 64; w++) begin
      mem[w] = {ref_mem[4*w+3], ref_mem[4*w+2], ref_mem[4*w+1], ref_mem[4*w]};
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!bus_req && !req_ready && !res_valid && !busy)
      else abort_run("outputs not idle after reset");
    // Store then signed load for every size at every offset
    for (int s = 0; s < 3; s++) begin
      for (int k = 0; k < 4; k++) begin
        issue_op(32'h3000_0000 + 32'(16 * (4 * s + k)), 32'(k), lsu_size_e'(s),
                 1'b1, 1'b0, stim_rand());
        issue_op(32'h3000_0000 + 32'(16 * (4 * s + k)), 32'(k), lsu_size_e'(s),
                 1'b0, 1'b1, '0);
      end
    end
    // Random mix issued back to back
    for (int n = 0; n < NUM_OPS - NUM_DIRECTED; n++) begin
      r = stim_rand();
      issue_op({8'h10, 16'h0, r[31:24]}, {28'h0, r[23:20]}, lsu_size_e'(r[19:18] % 2'd3),
               r[17], r[16], stim_rand());
    end
    req_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);                         // Last edge's assertions have settled
    if (!busy && u_lsu_top.u_lsu_assertions.fail_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "unit still busy or an assertion failed at the end");
    end
  end

endmodule

`default_nettype wire

// File: lsu_assertions.sv
// Bus protocol and outstanding count assertions that the testbench binds into the load/store unit top
`default_nettype none

module lsu_assertions #(
  parameter int MAX_OUTSTANDING = 2
) (
  input wire logic             clk,
  input wire logic             rst_n,
  input wire logic             bus_req_o,
  input wire lsu_pkg::bus_req_t bus_o,
  input wire logic             bus_gnt_i,
  input wire logic             bus_rvalid_i,
  input wire logic             busy_o
);

  int unsigned fail_cnt = 0;   // Assertion failures so far
  int          in_flight;      // Grants without a response yet

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(bus_req_o && bus_gnt_i) - int'(bus_rvalid_i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus protocol
  //////////////////////////////////////////////////////////////////////

  // Ungranted request stays up with the same fields
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o && !bus_gnt_i |=> bus_req_o && $stable(bus_o))
    else begin fail_cnt++; $error("request dropped or changed before its grant"); end

  count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight <= MAX_OUTSTANDING)
    else begin fail_cnt++; $error("more transactions in flight than allowed"); end

  busy_flag: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight != 0 |-> busy_o)
    else begin fail_cnt++; $error("busy low with transactions in flight"); end

endmodule

`default_nettype wire

// File: lsu_top.sv
// Top level of the load/store unit, connects the execute stage, the data bus and write-back
`default_nettype none

module lsu_top #(
  parameter int MAX_OUTSTANDING = 2   // Transactions allowed in flight
) (
  input  wire logic              clk,
  input  wire logic              rst_n,

  // Core request
  input  wire logic              req_valid_i,
  input  wire lsu_pkg::lsu_req_t req_i,
  output logic                   req_ready_o,

  // Core result
  output logic                   res_valid_o,
  output lsu_pkg::word_t         res_rdata_o,
  output logic                   busy_o,

  // OBI-style data bus
  output logic                   bus_req_o,
  output lsu_pkg::bus_req_t      bus_o,
  input  wire logic              bus_gnt_i,
  input  wire logic              bus_rvalid_i,
  input  wire lsu_pkg::word_t    bus_rdata_i
);

  import lsu_pkg::*;

  logic     split;       // First half of a split
  logic     last;        // Transfer ends the instruction
  logic     grant;       // Transfer accepted
  logic     rsp_valid;
  wb_ctrl_t rsp_ctrl;    // Head of the control queue

  //////////////////////////////////////////////////////////////////////
  // Execute side
  //////////////////////////////////////////////////////////////////////

  lsu_addr_gen u_addr_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .grant_i     (grant),
    .issue_o     (bus_o),         // Straight onto the bus
    .split_o     (split),
    .last_o      (last)
  );

  lsu_txn_ctrl #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_txn_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .split_i      (split),
    .last_i       (last),
    .req_i        (req_i),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_req_o    (bus_req_o),
    .grant_o      (grant),
    .req_ready_o  (req_ready_o),
    .busy_o       (busy_o),
    .rsp_valid_o  (rsp_valid),
    .rsp_ctrl_o   (rsp_ctrl)
  );

  //////////////////////////////////////////////////////////////////////
  // Write-back side
  //////////////////////////////////////////////////////////////////////

  lsu_rdata_align u_rdata_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .rsp_valid_i (rsp_valid),
    .rsp_ctrl_i  (rsp_ctrl),
    .bus_rdata_i (bus_rdata_i),
    .res_valid_o (res_valid_o),
    .res_rdata_o (res_rdata_o)
  );

endmodule

`default_nettype wire

// File: lsu_rdata_align.sv
// Write-back stage instantiated by the load/store unit top to merge, realign and extend read data
`default_nettype none

module lsu_rdata_align (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              rsp_valid_i,   // Bus response this cycle
  input  wire lsu_pkg::wb_ctrl_t rsp_ctrl_i,    // Control entry of that response
  input  wire lsu_pkg::word_t    bus_rdata_i,
  output logic                   res_valid_o,   // One per instruction
  output lsu_pkg::word_t         res_rdata_o
);

  import lsu_pkg::*;

  word_t       rdata_q;       // Raw word of a split load's first half
  logic        is_split;
  logic [63:0] rdata_full;    // Upper word over lower word
  word_t       rdata_shift;   // Realigned word in the low lanes
  word_t       rdata_ext;

  // First half of a split load keeps its raw word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rsp_valid_i && !rsp_ctrl_i.last && !rsp_ctrl_i.we) begin
      rdata_q <= bus_rdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Realignment
  //////////////////////////////////////////////////////////////////////

  // Same crossing rule as the execute side
  assign is_split = ((rsp_ctrl_i.size == SIZE_WORD) && (rsp_ctrl_i.offset != 2'b00)) ||
                    ((rsp_ctrl_i.size == SIZE_HALF) && (rsp_ctrl_i.offset == 2'b11));

  // Unsplit word doubled so the shift wraps upper lanes down
  assign rdata_full  = is_split ? {bus_rdata_i, rdata_q} : {bus_rdata_i, bus_rdata_i};
  assign rdata_shift = word_t'(rdata_full >> {rsp_ctrl_i.offset, 3'b000});

  //////////////////////////////////////////////////////////////////////
  // Extension
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (rsp_ctrl_i.size)
      SIZE_BYTE: rdata_ext = {{24{rsp_ctrl_i.sext && rdata_shift[7]}}, rdata_shift[7:0]};
      SIZE_HALF: rdata_ext = {{16{rsp_ctrl_i.sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:   rdata_ext = rdata_shift;
    endcase
  end

  // Result only on the last part of loads and stores
  assign res_valid_o = rsp_valid_i && rsp_ctrl_i.last;
  assign res_rdata_o = rdata_ext;

endmodule

`default_nettype wire

// File: lsu_txn_ctrl.sv
// Bus handshake of the load/store unit: outstanding count and queue of write-back control entries
`default_nettype none

module lsu_txn_ctrl #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              req_valid_i,
  input  wire logic              split_i,       // First half of a split in progress
  input  wire logic              last_i,        // Transfer ends the instruction
  input  wire lsu_pkg::lsu_req_t req_i,
  input  wire logic              bus_gnt_i,
  input  wire logic              bus_rvalid_i,
  output logic                   bus_req_o,
  output logic                   grant_o,       // Transfer accepted this cycle
  output logic                   req_ready_o,   // Instruction address phase done
  output logic                   busy_o,
  output logic                   rsp_valid_o,
  output lsu_pkg::wb_ctrl_t      rsp_ctrl_o     // Entry of the current response
);

  import lsu_pkg::*;

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [PTR_W-1:0] ptr_t;

  cnt_t     cnt_q;                          // Transactions in flight
  cnt_t     cnt_d;
  ptr_t     wr_ptr_q;                       // Push on grant
  ptr_t     rd_ptr_q;                       // Pop on response
  wb_ctrl_t queue_q [MAX_OUTSTANDING];      // One entry per transaction in flight
  wb_ctrl_t entry;                          // Entry for the transfer being granted

  // Wrap a queue pointer at the queue depth
  function automatic ptr_t next_ptr(ptr_t p);
    if (p == PTR_W'(MAX_OUTSTANDING - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  assign bus_req_o   = req_valid_i && (cnt_q < CNT_W'(MAX_OUTSTANDING)); // No room, hold off
  assign grant_o     = bus_req_o && bus_gnt_i;
  assign req_ready_o = grant_o && last_i;
  assign busy_o      = (cnt_q != '0) || req_valid_i;

  //////////////////////////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case ({grant_o, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;      // Idle, or grant and response cancel out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write-back control queue
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    entry.size   = req_i.size;
    entry.sext   = req_i.sext;
    entry.we     = req_i.we;
    entry.offset = req_i.op_a[1:0] + req_i.op_b[1:0];  // Low bits of the address sum
    entry.last   = !split_i;
  end

  // Pointers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (grant_o) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (bus_rvalid_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
    end
  end

  // Entry storage, written only on grant
  always_ff @(posedge clk) begin
    if (grant_o) begin
      queue_q[wr_ptr_q] <= entry;
    end
  end

  // Responses are in order, so the head belongs to the response
  assign rsp_valid_o = bus_rvalid_i;
  assign rsp_ctrl_o  = queue_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: lsu_addr_gen.sv
// Execute side of the load/store unit: address, byte enables, store data rotation and split phase
`default_nettype none

module lsu_addr_gen (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              req_valid_i,  // Core has an access pending
  input  wire lsu_pkg::lsu_req_t req_i,
  input  wire logic              grant_i,      // Current transfer accepted by bus
  output lsu_pkg::bus_req_t      issue_o,      // Transfer to put on the bus
  output logic                   split_o,      // First half of a split access
  output logic                   last_o        // Last transfer of this instruction
);

  import lsu_pkg::*;

  addr_t   addr;          // Effective address
  offset_t offset;        // Byte offset of effective address
  be_t     be;
  word_t   wdata_rot;     // Store data moved onto its byte lanes
  logic    needs_split;   // Access crosses a word boundary
  split_e  split_q;       // Which half is being issued

  assign addr   = req_i.op_a + req_i.op_b;
  assign offset = addr[1:0];

  //////////////////////////////////////////////////////////////////////
  // Split detection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    needs_split = 1'b0;
    unique case (req_i.size)
      SIZE_HALF: needs_split = (offset == 2'b11);   // Only last lane crosses
      SIZE_BYTE: needs_split = 1'b0;                // Never crosses
      default:   needs_split = (offset != 2'b00);   // Any unaligned word
    endcase
  end

  // Split only flagged while issuing the first half
  assign split_o = req_valid_i && (split_q == SPLIT_FIRST) && needs_split;
  assign last_o  = !split_o;

  //////////////////////////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    be = 4'b0000;
    unique case (req_i.size)
      SIZE_BYTE: be = 4'b0001 << offset;
      SIZE_HALF: begin
        if (split_q == SPLIT_FIRST) begin
          be = 4'b0011 << offset;                   // Upper lane cut at bit 3
        end else begin
          be = 4'b0001;                             // Remaining byte in next word
        end
      end
      default: begin
        if (split_q == SPLIT_FIRST) begin
          be = 4'b1111 << offset;                   // Lanes offset..3
        end else begin
          be = (4'b0001 << offset) - 4'b0001;       // Offset count of low lanes
        end
      end
    endcase
  end

  // Rotate store data left by whole bytes, both halves share it
  always_comb begin
    unique case (offset)
      2'b00: wdata_rot = req_i.wdata;
      2'b01: wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10: wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Bus transfer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    issue_o.we    = req_i.we;
    issue_o.be    = be;
    issue_o.wdata = wdata_rot;
    // Second half always starts at the next aligned word
    if (split_q == SPLIT_SECOND) begin
      issue_o.addr = {addr[31:2], 2'b00} + 32'd4;
    end else begin
      issue_o.addr = addr;
    end
  end

  // Split phase register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= SPLIT_FIRST;
    end else if (!req_valid_i) begin
      split_q <= SPLIT_FIRST;                       // Idle, next access starts fresh
    end else if (grant_i) begin
      split_q <= split_o ? SPLIT_SECOND : SPLIT_FIRST;
    end
  end

endmodule

`default_nettype wire

// File: lsu_pkg.sv
// Shared types, size codes and bus/write-back structs of the load/store unit, imported by all RTL
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;    // Data word
  typedef logic [31:0] addr_t;    // Byte address
  typedef logic [3:0]  be_t;      // One enable per byte lane
  typedef logic [1:0]  offset_t;  // Byte offset inside a word

  // Access size, same encoding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Phase of a possibly split access
  typedef enum logic {
    SPLIT_FIRST  = 1'b0,
    SPLIT_SECOND = 1'b1
  } split_e;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  // Request from the execute stage
  typedef struct packed {
    word_t     op_a;   // Base register
    word_t     op_b;   // Immediate offset
    word_t     wdata;  // Store data, unaligned
    logic      we;     // 1 for store
    lsu_size_e size;
    logic      sext;   // Sign-extend loaded value
  } lsu_req_t;

  // Address phase of one bus transaction
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    word_t wdata;
  } bus_req_t;

  // Write-back info kept per transaction in flight
  typedef struct packed {
    lsu_size_e size;
    logic      sext;
    logic      we;
    offset_t   offset;  // Offset of the original access
    logic      last;    // Low only for first half of a split
  } wb_ctrl_t;

endpackage

`default_nettype wire
